/* fetch_sub.f */
rtl/fetch_pkg.sv
rtl/pipe_reg.sv
rtl/redirect_hold.sv
rtl/fetch_pc.sv
rtl/inst_cache.sv
rtl/fetch_top.sv
verif/tb_clock.sv
verif/fetch_tb.sv

/* rtl/fetch_pc.sv */
`default_nettype none

// program counter stage feeding the icache and the IF bundle register
module fetch_pc
	import fetch_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  var  fetch_ctrl_t ctrl_i,
	input  wire logic        cache_stall_i,
	input  wire logic [31:0] cache_inst_i,
	output logic [31:0]      fetch_addr_o,
	output logic             fetch_req_o,
	output fetch_bundle_t    if_out_o
);

	logic [31:0]   pc_q;
	logic [31:0]   pc_next;
	logic          frozen;
	logic          misaligned;
	logic          kill;
	redirect_t     branch_eff;
	redirect_t     exc_eff;
	logic          inslot_eff;
	exc_vec_t      excs_d;
	fetch_bundle_t bundle_d;

	assign frozen     = cache_stall_i | ctrl_i.stall;
	assign misaligned = |pc_q[1:0];

	redirect_hold u_hold (
		.clk      (clk),
		.rst_n    (rst_n),
		.frozen_i (frozen),
		.branch_i (ctrl_i.branch),
		.exc_i    (ctrl_i.exc),
		.inslot_i (ctrl_i.inslot),
		.branch_o (branch_eff),
		.exc_o    (exc_eff),
		.inslot_o (inslot_eff)
	);

	// exception beats branch beats sequential
	always_comb begin
		if (exc_eff.valid) begin
			pc_next = exc_eff.target;
		end else if (branch_eff.valid) begin
			pc_next = branch_eff.target;
		end else begin
			pc_next = pc_q + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_PC;
		end else if (!frozen) begin
			pc_q <= pc_next;
		end
	end

	assign fetch_addr_o = pc_q;
	assign fetch_req_o  = !misaligned & !ctrl_i.stall;	// bad pc never reaches memory

	// entry captured this cycle gets dropped
	assign kill = ctrl_i.if_flush | exc_eff.valid;

	always_comb begin
		excs_d           = '0;
		excs_d[EXC_ADEL] = misaligned;

		bundle_d.valid   = !kill;
		bundle_d.pc      = pc_q;
		bundle_d.inst    = (kill | misaligned) ? 32'h0 : cache_inst_i;
		bundle_d.excs    = kill ? '0 : excs_d;
		bundle_d.has_exc = misaligned & !kill;
		bundle_d.inslot  = inslot_eff & !kill;
	end

	// held under controller stall and cleared while memory is busy
	pipe_reg #(.T(fetch_bundle_t)) u_if_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.en_i  (!frozen),
		.clr_i (cache_stall_i & !ctrl_i.stall),
		.d_i   (bundle_d),
		.q_o   (if_out_o)
	);

	// a misaligned pc asks nothing of memory and never waits on the cache
	no_misaligned_req: assert property (@(posedge clk) disable iff (!rst_n)
		misaligned |-> !fetch_req_o && !cache_stall_i);

endmodule

`default_nettype wire

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	localparam logic [31:0] RESET_PC = 32'hbfc0_0000;	// boot rom, kseg1

	// exception vector layout
	localparam int EXC_W    = 8;
	localparam int EXC_ADEL = 1;	// address error on fetch

	// icache geometry, one word per line
	localparam int CACHE_LINES = 16;
	localparam int CACHE_IDX_W = $clog2(CACHE_LINES);
	localparam int CACHE_TAG_W = 30 - CACHE_IDX_W;

	localparam logic [2:0] UNCACHED_SEG = 3'b101;	// kseg1 goes straight to memory

	typedef logic [EXC_W-1:0] exc_vec_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	// controller side, all levels
	typedef struct packed {
		logic      stall;
		logic      if_flush;
		redirect_t branch;
		redirect_t exc;
		logic      inslot;	// next fetched word sits in a delay slot
	} fetch_ctrl_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] inst;
		exc_vec_t    excs;
		logic        has_exc;
		logic        inslot;
	} fetch_bundle_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* rtl/fetch_top.sv */
`default_nettype none

// instruction fetch subsystem
module fetch_top
	import fetch_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  var  fetch_ctrl_t ctrl_i,
	output mem_req_t         mem_req_o,
	input  var  mem_rsp_t    mem_rsp_i,
	output fetch_bundle_t    if_out_o
);

	logic [31:0] fetch_addr;
	logic        fetch_req;
	logic [31:0] cache_inst;
	logic        cache_stall;

	fetch_pc u_fetch_pc (
		.clk           (clk),
		.rst_n         (rst_n),
		.ctrl_i        (ctrl_i),
		.cache_stall_i (cache_stall),
		.cache_inst_i  (cache_inst),
		.fetch_addr_o  (fetch_addr),
		.fetch_req_o   (fetch_req),
		.if_out_o      (if_out_o)
	);

	// answers in the same cycle, stalls on miss
	inst_cache u_icache (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_i     (fetch_req),
		.addr_i    (fetch_addr),
		.inst_o    (cache_inst),
		.stall_o   (cache_stall),
		.mem_req_o (mem_req_o),
		.mem_rsp_i (mem_rsp_i)
	);

endmodule

`default_nettype wire

/* rtl/inst_cache.sv */
`default_nettype none

// direct mapped icache, one word per line, kseg1 bypasses
module inst_cache
	import fetch_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        req_i,
	input  wire logic [31:0] addr_i,
	output logic [31:0]      inst_o,
	output logic             stall_o,
	output mem_req_t         mem_req_o,
	input  var  mem_rsp_t    mem_rsp_i
);

	typedef enum logic {
		S_IDLE,
		S_WAIT	// request out, waiting for the word
	} state_t;

	state_t                 state_q;
	logic [CACHE_TAG_W-1:0] tag_mem [CACHE_LINES];
	logic [31:0]            data_mem [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_q;
	logic [CACHE_IDX_W-1:0] idx;
	logic [CACHE_TAG_W-1:0] tag;
	logic                   uncached;
	logic                   hit;
	logic                   miss;
	logic                   rsp_uc;
	logic                   uc_held;	// uncached word parked during a stall
	logic [31:0]            uc_data;
	mem_req_t               req_q;

	assign idx      = addr_i[CACHE_IDX_W+1:2];
	assign tag      = addr_i[31:CACHE_IDX_W+2];
	assign uncached = addr_i[31:29] == UNCACHED_SEG;
	assign hit      = !uncached && valid_q[idx] && tag_mem[idx] == tag;
	assign miss     = state_q == S_IDLE && req_i && !uc_held && !hit;
	assign rsp_uc   = state_q == S_WAIT && mem_rsp_i.valid && uncached;

	always_comb begin
		if (rsp_uc) begin
			inst_o = mem_rsp_i.data;	// pass through
		end else if (uc_held) begin
			inst_o = uc_data;
		end else begin
			inst_o = data_mem[idx];
		end
	end

	assign stall_o   = (state_q == S_WAIT) ? !(rsp_uc && req_i) : miss;
	assign mem_req_o = req_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= S_IDLE;
			req_q   <= '0;
			valid_q <= '0;
			uc_held <= 1'b0;
		end else begin
			req_q.valid <= 1'b0;	// one cycle strobe
			case (state_q)
				S_IDLE: begin
					if (miss) begin
						state_q <= S_WAIT;
						req_q   <= '{valid: 1'b1, addr: {addr_i[31:2], 2'b00}};
					end
					if (req_i) begin
						uc_held <= 1'b0;
					end
				end
				S_WAIT: begin
					if (mem_rsp_i.valid) begin
						state_q <= S_IDLE;
						if (!uncached) begin
							valid_q[idx] <= 1'b1;
						end else if (!req_i) begin
							uc_held <= 1'b1;
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// refill / uncached capture
	always_ff @(posedge clk) begin
		if (state_q == S_WAIT && mem_rsp_i.valid) begin
			if (uncached) begin
				uc_data <= mem_rsp_i.data;
			end else begin
				tag_mem[idx]  <= tag;
				data_mem[idx] <= mem_rsp_i.data;
			end
		end
	end

	rsp_only_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rsp_i.valid |-> state_q == S_WAIT);

	req_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_o.valid |=> !mem_req_o.valid);

endmodule

`default_nettype wire

/* rtl/pipe_reg.sv */
`default_nettype none

// pipeline register, clear beats enable
module pipe_reg #(
	parameter type T = logic
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic en_i,
	input  wire logic clr_i,
	input  var  T     d_i,
	output T          q_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q_o <= '0;
		end else if (clr_i) begin
			q_o <= '0;	// bubble
		end else if (en_i) begin
			q_o <= d_i;
		end
	end

endmodule

`default_nettype wire

/* rtl/redirect_hold.sv */
`default_nettype none

// keeps branch / exception redirects that show up while fetch is frozen
module redirect_hold
	import fetch_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire logic      frozen_i,	// cache or controller stall
	input  var  redirect_t branch_i,
	input  var  redirect_t exc_i,
	input  wire logic      inslot_i,
	output redirect_t      branch_o,
	output redirect_t      exc_o,
	output logic           inslot_o
);

	redirect_t held_br;
	redirect_t held_exc;
	logic      held_slot;
	logic      br_clr;

	// first free cycle consumes whatever is held
	assign br_clr = !frozen_i | exc_i.valid;	// newer exception drops a pending branch

	pipe_reg #(.T(redirect_t)) u_held_br (
		.clk   (clk),
		.rst_n (rst_n),
		.en_i  (frozen_i & branch_i.valid),
		.clr_i (br_clr),
		.d_i   (branch_i),
		.q_o   (held_br)
	);

	pipe_reg #(.T(redirect_t)) u_held_exc (
		.clk   (clk),
		.rst_n (rst_n),
		.en_i  (frozen_i & exc_i.valid),
		.clr_i (!frozen_i),
		.d_i   (exc_i),
		.q_o   (held_exc)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			held_slot <= 1'b0;
		end else if (!frozen_i) begin
			held_slot <= 1'b0;
		end else if (inslot_i) begin
			held_slot <= 1'b1;
		end
	end

	assign branch_o = held_br.valid ? held_br : branch_i;
	assign exc_o    = held_exc.valid ? held_exc : exc_i;
	assign inslot_o = held_slot | inslot_i;

	// a held redirect is used exactly once, on the first free cycle
	hold_consumed: assert property (@(posedge clk) disable iff (!rst_n)
		!frozen_i |=> !held_br.valid && !held_exc.valid);

endmodule

`default_nettype wire

/* verif/fetch_tb.sv */
`default_nettype none

module fetch_tb
	import fetch_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          TIMEOUT = 200;	// cycles per wait
	localparam logic [31:0] XOR_KEY = 32'ha5a5_a5a5;

	logic          clk;
	logic          rst_n;
	fetch_ctrl_t   ctrl;
	mem_req_t      mem_req;
	mem_rsp_t      mem_rsp;
	fetch_bundle_t if_out;
	mem_req_t      req_log [$];	// requests since the last bundle
	int            req_total = 0;
	int            checks = 0;
	int            errors = 0;

	tb_clock u_clock (.clk_o(clk));

	fetch_top fetch_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl_i    (ctrl),
		.mem_req_o (mem_req),
		.mem_rsp_i (mem_rsp),
		.if_out_o  (if_out)
	);

	// memory answers each request after 1 to 4 cycles with address ^ key
	initial begin : mem_model
		int       seed;
		int       delay;
		mem_req_t req;
		seed = 97014;
		void'($urandom(seed));
		mem_rsp = '0;
		forever begin
			@(posedge clk);
			#1;
			if (mem_req.valid) begin
				req = mem_req;
				req_log.push_back(req);
				req_total++;
				delay = 1 + int'($urandom % 4);
				repeat (delay) @(posedge clk);
				#1;
				mem_rsp.valid = 1'b1;
				mem_rsp.data  = req.addr ^ XOR_KEY;
				@(posedge clk);
				#1;
				mem_rsp = '0;	// one cycle strobe
			end
		end
	end

	function automatic fetch_bundle_t predict_bundle(input logic [31:0] pc, input logic slot);
		fetch_bundle_t b;
		b        = '0;
		b.valid  = 1'b1;
		b.pc     = pc;
		b.inslot = slot;
		if (pc[1:0] != 2'b00) begin
			b.excs[EXC_ADEL] = 1'b1;	// address error leaves the word at 0
			b.has_exc        = 1'b1;
		end else begin
			b.inst = pc ^ XOR_KEY;
		end
		return b;
	endfunction

	function automatic redirect_t to_target(input logic [31:0] target);
		redirect_t r;
		r.valid  = 1'b1;
		r.target = target;
		return r;
	endfunction

	task automatic check_bundle(input fetch_bundle_t got, input fetch_bundle_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got v=%b pc=%h inst=%h exc=%h/%b slot=%b", $time, what,
				got.valid, got.pc, got.inst, got.excs, got.has_exc, got.inslot);
			$display("  expected v=%b pc=%h inst=%h exc=%h/%b slot=%b", exp.valid, exp.pc,
				exp.inst, exp.excs, exp.has_exc, exp.inslot);
		end
	endtask

	task automatic check_req(input mem_req_t got, input mem_req_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got v=%b addr=%h expected v=%b addr=%h", $time, what,
				got.valid, got.addr, exp.valid, exp.addr);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// sampled 1 ns after the edge where the IF register has settled
	task automatic next_bundle(output fetch_bundle_t b);
		logic found;
		found = 1'b0;
		for (int n = 0; n < TIMEOUT && !found; n++) begin
			@(posedge clk);
			#1;
			found = if_out.valid;
		end
		b = if_out;
		if (!found) begin
			errors++;
			$display("timeout: no valid fetch bundle within %0d cycles at %0t",
				TIMEOUT, $time);
		end
	endtask

	task automatic wait_mem_req();
		logic found;
		found = 1'b0;
		for (int n = 0; n < TIMEOUT && !found; n++) begin
			@(posedge clk);
			#1;
			found = mem_req.valid;
		end
		if (!found) begin
			errors++;
			$display("timeout: no memory request within %0d cycles at %0t",
				TIMEOUT, $time);
		end
	endtask

	// one bundle and the requests logged since the last one
	// a negative reqs leaves the request log unchecked
	task automatic expect_fetch(input logic [31:0] pc, input logic slot, input int reqs);
		fetch_bundle_t b;
		mem_req_t      exp_req;
		next_bundle(b);
		check_bundle(b, predict_bundle(pc, slot), $sformatf("bundle %h", pc));
		if (reqs >= 0) begin
			check_count(req_log.size(), reqs, $sformatf("requests for %h", pc));
			exp_req.valid = 1'b1;
			exp_req.addr  = pc;
			foreach (req_log[i]) begin
				check_req(req_log[i], exp_req, $sformatf("request for %h", pc));
			end
		end
		req_log.delete();
	endtask

	task automatic run_words(input logic [31:0] start, input int n, input int reqs);
		for (int k = 0; k < n; k++) begin
			expect_fetch(start + 32'(4 * k), 1'b0, reqs);
		end
	endtask

	// redirect levels held for one cycle until 1 ns after the next edge
	task automatic pulse_redirect(input redirect_t br, input redirect_t exc, input logic slot);
		ctrl.branch = br;
		ctrl.exc    = exc;
		ctrl.inslot = slot;
		fork
			begin
				@(posedge clk);
				#1;
				ctrl.branch = '0;
				ctrl.exc    = '0;
				ctrl.inslot = 1'b0;
			end
		join_none
	endtask

	task automatic fetch_from_reset();
		run_words(RESET_PC, 4, 1);	// kseg1 sends every word to memory
	endtask

	task automatic refill_and_hit();
		pulse_redirect(to_target(32'h1000), '0, 1'b0);
		expect_fetch(RESET_PC + 32'h10, 1'b0, 1);	// delay slot
		run_words(32'h1000, 8, 1);
		pulse_redirect(to_target(32'h1000), '0, 1'b0);
		expect_fetch(32'h1020, 1'b0, 1);
		run_words(32'h1000, 8, 0);	// second pass all hits
	endtask

	task automatic stall_and_flush();
		fetch_bundle_t held;
		// 0x1020 hits so the flushed cycle is free
		ctrl.if_flush = 1'b1;
		@(posedge clk);
		#1;
		ctrl.if_flush = 1'b0;
		expect_fetch(32'h1024, 1'b0, 1);
		held       = predict_bundle(32'h1024, 1'b0);
		ctrl.stall = 1'b1;
		repeat (6) begin
			@(posedge clk);
			#1;
			check_bundle(if_out, held, "bundle under stall");
		end
		ctrl.stall = 1'b0;
		expect_fetch(32'h1028, 1'b0, 1);
	endtask

	task automatic branch_redirects();
		wait_mem_req();	// 0x102c refilling
		pulse_redirect(to_target(32'h1000), '0, 1'b1);
		expect_fetch(32'h102c, 1'b1, 1);
		expect_fetch(32'h1000, 1'b0, 0);
		pulse_redirect(to_target(32'h1010), '0, 1'b1);	// 0x1004 hits in a free cycle
		expect_fetch(32'h1004, 1'b1, 0);
		expect_fetch(32'h1010, 1'b0, 0);
	endtask

	task automatic exception_redirects();
		// the hit on 0x1014 is dropped and the branch loses
		pulse_redirect(to_target(32'h6000), to_target(32'h8000_0238), 1'b0);
		expect_fetch(32'h8000_0238, 1'b0, 1);
		expect_fetch(32'h8000_023c, 1'b0, 1);
		wait_mem_req();
		pulse_redirect('0, to_target(32'h8000_0380), 1'b0);
		expect_fetch(32'h8000_0380, 1'b0, -1);	// killed fetch also went out
		expect_fetch(32'h8000_0384, 1'b0, 1);
	endtask

	task automatic misaligned_target();
		pulse_redirect(to_target(32'h2002), '0, 1'b0);
		expect_fetch(32'h8000_0388, 1'b0, 1);
		expect_fetch(32'h2002, 1'b0, 0);
		pulse_redirect(to_target(32'h3000), '0, 1'b0);
		expect_fetch(32'h2006, 1'b0, 0);
		expect_fetch(32'h3000, 1'b0, 1);
	endtask

	initial begin
		rst_n = 1'b0;
		ctrl  = '0;
		repeat (8) @(posedge clk);
		#1;
		check_bundle(if_out, '0, "bundle in reset");
		check_req(mem_req, '0, "request in reset");
		rst_n = 1'b1;
		// each test leaves the pc where the next one picks up
		fetch_from_reset();
		refill_and_hit();
		stall_and_flush();
		branch_redirects();
		exception_redirects();
		misaligned_target();
		$display("done: %0d checks, %0d errors, %0d memory requests",
			checks, errors, req_total);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`default_nettype none

// free running testbench clock, 10 ns period
module tb_clock (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;	// half period
	end

endmodule

`default_nettype wire
